/* board_pkg.sv */
package board_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   localparam int data_width     = 16; // Bus, register and address width
   localparam int reg_count      = 8;  // Registers in the octal bank
   localparam int reg_sel_width  = 3;  // Register index
   localparam int flag_count     = 4;  // JK status flags
   localparam int flag_sel_width = 2;  // Flag index

   //////////////////////////////
   // Microword fields
   //////////////////////////////

   // Who drives the internal bus this cycle
   typedef enum logic [2:0] {
      SRC_NONE  = 3'd0, // Idle bus pulled down to zero
      SRC_EXT   = 3'd1, // External data port
      SRC_REG   = 3'd2, // Bank read port
      SRC_ADDR  = 3'd3, // Memory address register
      SRC_FLAGS = 3'd4  // Status flags, zero-extended
   } bus_src_t;

   // Who latches the bus at the coming edge
   typedef enum logic [1:0] {
      DST_NONE = 2'd0,
      DST_REG  = 2'd1, // Register named by reg_sel
      DST_ADDR = 2'd2  // Memory address register
   } bus_dst_t;

   // Operation on the flag named by flag_sel
   typedef enum logic [1:0] {
      FLAG_HOLD   = 2'd0, // J=0 K=0
      FLAG_CLEAR  = 2'd1, // J=0 K=1
      FLAG_SET    = 2'd2, // J=1 K=0
      FLAG_TOGGLE = 2'd3  // J=1 K=1
   } flag_op_t;

   // One microword, 13 bits, presented every cycle
   typedef struct packed {
      bus_src_t                  src;
      bus_dst_t                  dst;
      logic [reg_sel_width-1:0]  reg_sel;  // Bank read and write index
      logic                      addr_inc; // Post-increment the address
      logic [flag_sel_width-1:0] flag_sel;
      flag_op_t                  flag_op;
   } micro_word_t;

   //////////////////////////////
   // Decoded controls
   //////////////////////////////

   typedef struct packed {
      logic [reg_count-1:0]  reg_load;  // One-hot or zero
      logic                  addr_load; // Latch bus into address
      logic                  addr_inc;  // Add one to address
      logic [flag_count-1:0] flag_j;    // Per-flag J inputs
      logic [flag_count-1:0] flag_k;    // Per-flag K inputs
   } strobe_t;

endpackage

/* microword_decoder.sv */
`timescale 1ns/10ps

// Microword to strobe decode
// Stands in for the 74x138 style decoders on the board
// Purely combinational
module microword_decoder (
   input  board_pkg::micro_word_t uword,
   output board_pkg::strobe_t     strobes
);

   import board_pkg::*;

   //////////////////////////////
   // Destination decode
   //////////////////////////////

   logic [reg_count-1:0] reg_onehot; // reg_sel as one-hot
   logic                 dst_reg;    // Bank is the destination
   logic                 dst_addr;   // Address register is the destination

   always_comb begin
      reg_onehot = '0;
      reg_onehot[uword.reg_sel] = 1'b1;
   end

   always_comb begin
      dst_reg  = 1'b0;
      dst_addr = 1'b0;
      case (uword.dst)
         DST_REG:  dst_reg  = 1'b1;
         DST_ADDR: dst_addr = 1'b1;
         default: begin
            // DST_NONE and the spare code latch nothing
            dst_reg  = 1'b0;
            dst_addr = 1'b0;
         end
      endcase
   end

   //////////////////////////////
   // Flag J/K decode
   //////////////////////////////

   logic j_sel; // J for the selected flag
   logic k_sel; // K for the selected flag

   always_comb begin
      case (uword.flag_op)
         FLAG_HOLD:   {j_sel, k_sel} = 2'b00;
         FLAG_CLEAR:  {j_sel, k_sel} = 2'b01;
         FLAG_SET:    {j_sel, k_sel} = 2'b10;
         FLAG_TOGGLE: {j_sel, k_sel} = 2'b11;
         default:     {j_sel, k_sel} = 2'b00;
      endcase
   end

   //////////////////////////////
   // Strobe assembly
   //////////////////////////////

   always_comb begin
      strobes           = '0;                          // Idle unless named
      strobes.reg_load  = dst_reg ? reg_onehot : '0;   // Only with DST_REG
      strobes.addr_load = dst_addr;
      strobes.addr_inc  = uword.addr_inc;              // Independent of dst
      strobes.flag_j[uword.flag_sel] = j_sel;          // Other flags stay 0/0
      strobes.flag_k[uword.flag_sel] = k_sel;
   end

endmodule

/* register_bank.sv */
`timescale 1ns/10ps

// Octal bank of 16-bit registers
// Each register is a pair of clearable 74x273 parts behind a 74x574 style
// output stage; the tri-state read bus becomes a multiplexer here
module register_bank (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic [board_pkg::reg_count-1:0]      reg_load,
   input  logic [board_pkg::data_width-1:0]     wr_data,
   input  logic [board_pkg::reg_sel_width-1:0]  rd_sel,
   output logic [board_pkg::data_width-1:0]     rd_data
);

   import board_pkg::*;

   //////////////////////////////
   // Storage
   //////////////////////////////

   logic [data_width-1:0] regs [reg_count]; // R0 .. R7

   // Write port
   // reg_load is one-hot or zero, so at most one register takes the bus
   always_ff @(posedge clk) begin
      if (!rst) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0; // Like the /CLR pin of the 273
         end
      end else begin
         for (int i = 0; i < reg_count; i++) begin
            if (reg_load[i]) begin
               regs[i] <= wr_data;
            end
         end
      end
   end

   //////////////////////////////
   // Read port
   //////////////////////////////

   // One output enable per register on the real board
   // The selected register drives, the rest float
   always_comb begin
      rd_data = regs[rd_sel];
   end

endmodule

/* address_register.sv */
`timescale 1ns/10ps

// Memory address register
// Counter with parallel load in the 74x161 style but 16 bits wide
module address_register (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             load,      // Take load_data
   input  logic                             inc,       // Post-increment
   input  logic [board_pkg::data_width-1:0] load_data,
   output logic [board_pkg::data_width-1:0] addr
);

   import board_pkg::*;

   //////////////////////////////
   // Next address
   //////////////////////////////

   logic [data_width-1:0] addr_next;

   // Priority order matches the board wiring
   always_comb begin
      if (load) begin
         addr_next = load_data;  // Load wins over increment
      end else if (inc) begin
         addr_next = addr + data_width'(1); // Wraps from all ones to zero
      end else begin
         addr_next = addr;
      end
   end

   //////////////////////////////
   // State
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst) begin
         addr <= '0;
      end else begin
         addr <= addr_next;
      end
   end

endmodule

/* jk_flag_unit.sv */
`timescale 1ns/10ps

// Four JK status flags
// Two 74x112 packages on the real board; here rising edge and synchronous
module jk_flag_unit (
   input  logic                             clk,
   input  logic                             rst,
   input  logic [board_pkg::flag_count-1:0] j,
   input  logic [board_pkg::flag_count-1:0] k,
   output logic [board_pkg::flag_count-1:0] flags
);

   import board_pkg::*;

   //////////////////////////////
   // Clocked truth table
   //////////////////////////////

   //  J K | Q next
   //  0 0 | Q
   //  0 1 | 0
   //  1 0 | 1
   //  1 1 | /Q

   logic [flag_count-1:0] flags_next;

   always_comb begin
      for (int i = 0; i < flag_count; i++) begin
         case ({j[i], k[i]})
            2'b01:   flags_next[i] = 1'b0;      // Clear
            2'b10:   flags_next[i] = 1'b1;      // Set
            2'b11:   flags_next[i] = ~flags[i]; // Toggle
            default: flags_next[i] = flags[i];  // Hold
         endcase
      end
   end

   //////////////////////////////
   // Flip-flops
   //////////////////////////////

   // /SET and /RST of the part fold into rst, which only clears
   always_ff @(posedge clk) begin
      if (!rst) begin
         flags <= '0;
      end else begin
         flags <= flags_next;
      end
   end

endmodule

/* register_board.sv */
`timescale 1ns/10ps

// Register board top level
// Decoder, octal bank, address register and status flags around one bus
module register_board (
   input  logic                             clk,
   input  logic                             rst,
   input  board_pkg::micro_word_t           uword,
   input  logic [board_pkg::data_width-1:0] ext_data,
   output logic [board_pkg::data_width-1:0] bus_data,
   output logic [board_pkg::data_width-1:0] addr,
   output logic [board_pkg::flag_count-1:0] flags
);

   import board_pkg::*;

   strobe_t               strobes;   // Decoded controls, same cycle as uword
   logic [data_width-1:0] bank_data; // Bank read port

   //////////////////////////////
   // Microword decode
   //////////////////////////////

   microword_decoder microword_decoder_inst (
      .uword   (uword),
      .strobes (strobes)
   );

   //////////////////////////////
   // Storage
   //////////////////////////////

   // Bank reads and writes the same index
   register_bank register_bank_inst (
      .clk      (clk),
      .rst      (rst),
      .reg_load (strobes.reg_load),
      .wr_data  (bus_data),
      .rd_sel   (uword.reg_sel),
      .rd_data  (bank_data)
   );

   address_register address_register_inst (
      .clk       (clk),
      .rst       (rst),
      .load      (strobes.addr_load),
      .inc       (strobes.addr_inc),
      .load_data (bus_data),
      .addr      (addr)
   );

   jk_flag_unit jk_flag_unit_inst (
      .clk   (clk),
      .rst   (rst),
      .j     (strobes.flag_j),
      .k     (strobes.flag_k),
      .flags (flags)
   );

   //////////////////////////////
   // Bus source multiplexer
   //////////////////////////////

   // Replaces the tri-state drivers with no register on this path
   always_comb begin
      case (uword.src)
         SRC_EXT:   bus_data = ext_data;
         SRC_REG:   bus_data = bank_data;
         SRC_ADDR:  bus_data = addr;
         SRC_FLAGS: bus_data = {{(data_width-flag_count){1'b0}}, flags}; // Zero-extend
         default:   bus_data = '0; // SRC_NONE and spare codes pull the bus low
      endcase
   end

endmodule

/* tb_register_board.sv */
`timescale 1ns/10ps

// Testbench for the register board
module tb_register_board;

   import board_pkg::*;

   // Everything the board stores
   typedef struct packed {
      logic [reg_count-1:0][data_width-1:0] regs;
      logic [data_width-1:0]                addr;
      logic [flag_count-1:0]                flags;
   } model_t;

   logic                  clk;
   logic                  rst;
   micro_word_t           uword;
   logic [data_width-1:0] ext_data;
   logic [data_width-1:0] bus_data;
   logic [data_width-1:0] addr;
   logic [flag_count-1:0] flags;

   model_t                model;        // State before the coming edge
   model_t                model_nxt;
   logic [data_width-1:0] exp_bus;      // Bus value the model expects now
   bit                    check_en;     // Off during power-up reset
   bit                    timed_out;
   int                    errors;
   int                    tests_passed;
   int                    tests_failed;
   int                    seed;

   register_board register_board_inst (
      .clk      (clk),
      .rst      (rst),
      .uword    (uword),
      .ext_data (ext_data),
      .bus_data (bus_data),
      .addr     (addr),
      .flags    (flags)
   );

   always #50 clk = ~clk; // 100 ns period

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic model_t next_state(input model_t cur, input micro_word_t w,
                                         input logic [data_width-1:0] ext,
                                         output logic [data_width-1:0] bus);
      model_t nxt;
      nxt = cur;
      case (w.src)
         SRC_EXT:   bus = ext;
         SRC_REG:   bus = cur.regs[w.reg_sel];
         SRC_ADDR:  bus = cur.addr;
         SRC_FLAGS: begin
            bus = '0;                        // Upper bits read low
            bus[flag_count-1:0] = cur.flags;
         end
         default:   bus = '0; // Idle bus reads zero
      endcase
      if (w.dst == DST_REG) nxt.regs[w.reg_sel] = bus;
      if (w.dst == DST_ADDR) begin
         nxt.addr = bus;                // Load beats increment
      end else if (w.addr_inc) begin
         nxt.addr = cur.addr + 16'd1;   // Wraps naturally
      end
      case (w.flag_op)
         FLAG_CLEAR:  nxt.flags[w.flag_sel] = 1'b0;
         FLAG_SET:    nxt.flags[w.flag_sel] = 1'b1;
         FLAG_TOGGLE: nxt.flags[w.flag_sel] = ~cur.flags[w.flag_sel];
         default:     ;                 // Hold
      endcase
      return nxt;
   endfunction

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic check_bus(input logic [data_width-1:0] got, input logic [data_width-1:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: bus_data is %h, expected %h", $time, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input logic [data_width-1:0] got, input logic [data_width-1:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: addr is %h, expected %h", $time, got, exp);
         errors++;
      end
   endtask

   task automatic check_flags(input logic [flag_count-1:0] got,
                              input logic [flag_count-1:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: flags are %b, expected %b", $time, got, exp);
         errors++;
      end
   endtask

   // Sample mid-cycle while the inputs are stable
   always @(negedge clk) begin
      model_nxt = next_state(model, uword, ext_data, exp_bus);
      if (check_en) begin
         check_bus(bus_data, exp_bus);
         check_addr(addr, model.addr);
         check_flags(flags, model.flags);
      end
      if (!rst) model = '0; // Reset at this edge ignores the strobes
      else      model = model_nxt;
   end

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////

   function automatic micro_word_t make_word(input bus_src_t src, input bus_dst_t dst,
                                             input logic [reg_sel_width-1:0] sel,
                                             input logic inc,
                                             input logic [flag_sel_width-1:0] fsel,
                                             input flag_op_t op);
      micro_word_t w;
      w.src      = src;
      w.dst      = dst;
      w.reg_sel  = sel;
      w.addr_inc = inc;
      w.flag_sel = fsel;
      w.flag_op  = op;
      return w;
   endfunction

   task automatic drive(input micro_word_t w, input logic [data_width-1:0] d);
      @(posedge clk);
      uword    <= w;
      ext_data <= d;
   endtask

   // Let the last word reach the compare process
   task automatic settle();
      @(negedge clk);
      #1;
   endtask

   task automatic report_test(input string name, input int err_before);
      if (errors == err_before) begin
         tests_passed++;
         $display("Test %s: ok", name);
      end else begin
         tests_failed++;
         $display("Test %s: %0d errors", name, errors - err_before);
      end
   endtask

   task automatic wait_reset_release(input int limit);
      int n;
      n = 0;
      while (rst !== 1'b1 && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (rst !== 1'b1) begin
         $display("Error: timeout waiting for reset release");
         timed_out = 1'b1;
      end
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      micro_word_t idle;
      micro_word_t w;
      logic [31:0] r1;
      logic [31:0] r2;
      int          e0;
      idle = make_word(SRC_NONE, DST_NONE, 3'd0, 1'b0, 2'd0, FLAG_HOLD);
      clk = 1'b0;
      rst      <= 1'b0;
      uword    <= idle;
      ext_data <= '0;
      model = '0;
      check_en = 1'b0;
      timed_out = 1'b0;
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      seed = 31;
      repeat (8) @(posedge clk); // 8 reset edges
      rst <= 1'b1;
      wait_reset_release(20);
      if (timed_out) begin
         $display("Some tests failed");
      end else begin
         check_en = 1'b1;
         // ext_data must not leak onto an idle bus
         e0 = errors;
         drive(idle, 16'hBEEF);
         settle();
         check_bus(bus_data, '0);
         check_addr(addr, '0);
         check_flags(flags, '0);
         report_test("reset state", e0);

         e0 = errors;
         for (int i = 0; i < reg_count; i++)
            drive(make_word(SRC_EXT, DST_REG, 3'(i), 1'b0, 2'd0, FLAG_HOLD),
                  16'(32'h0a05 + i * 32'h1111));
         for (int i = 0; i < reg_count; i++)
            drive(make_word(SRC_REG, DST_NONE, 3'(i), 1'b0, 2'd0, FLAG_HOLD), 16'h0);
         drive(make_word(SRC_REG, DST_REG, 3'd3, 1'b0, 2'd0, FLAG_HOLD), 16'h0);  // Self move
         drive(make_word(SRC_REG, DST_ADDR, 3'd2, 1'b0, 2'd0, FLAG_HOLD), 16'h0); // R2 out
         drive(make_word(SRC_ADDR, DST_REG, 3'd6, 1'b0, 2'd0, FLAG_HOLD), 16'h0); // into R6
         drive(make_word(SRC_REG, DST_NONE, 3'd6, 1'b0, 2'd0, FLAG_HOLD), 16'h0);
         drive(make_word(SRC_REG, DST_NONE, 3'd3, 1'b0, 2'd0, FLAG_HOLD), 16'h0);
         settle();
         report_test("register write and read-back", e0);

         e0 = errors;
         drive(make_word(SRC_EXT, DST_ADDR, 3'd0, 1'b0, 2'd0, FLAG_HOLD), 16'h1234);
         repeat (3) drive(make_word(SRC_NONE, DST_NONE, 3'd0, 1'b1, 2'd0, FLAG_HOLD), 16'h0);
         drive(make_word(SRC_EXT, DST_ADDR, 3'd0, 1'b0, 2'd0, FLAG_HOLD), 16'hFFFD);
         repeat (4) drive(make_word(SRC_NONE, DST_NONE, 3'd0, 1'b1, 2'd0, FLAG_HOLD), 16'h0);
         drive(make_word(SRC_EXT, DST_ADDR, 3'd0, 1'b1, 2'd0, FLAG_HOLD), 16'h4000);
         drive(make_word(SRC_ADDR, DST_NONE, 3'd0, 1'b0, 2'd0, FLAG_HOLD), 16'h0);
         settle();
         check_addr(addr, 16'h4000);     // Load wins over increment
         check_bus(bus_data, 16'h4000);
         report_test("address register", e0);

         e0 = errors;
         for (int f = 0; f < flag_count; f++) begin
            drive(make_word(SRC_FLAGS, DST_NONE, 3'd0, 1'b0, 2'(f), FLAG_SET), 16'h0);
            drive(make_word(SRC_FLAGS, DST_NONE, 3'd0, 1'b0, 2'(f), FLAG_HOLD), 16'h0);
            drive(make_word(SRC_FLAGS, DST_NONE, 3'd0, 1'b0, 2'(f), FLAG_TOGGLE), 16'h0);
            drive(make_word(SRC_FLAGS, DST_NONE, 3'd0, 1'b0, 2'(f), FLAG_CLEAR), 16'h0);
         end
         drive(make_word(SRC_FLAGS, DST_NONE, 3'd0, 1'b0, 2'd0, FLAG_HOLD), 16'h0);
         settle();
         report_test("jk flags", e0);

         e0 = errors;
         for (int n = 0; n < 400; n++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            w.src      = bus_src_t'(3'(r1 % 5));
            w.dst      = bus_dst_t'(2'(r2 % 3));
            w.reg_sel  = r1[10:8];
            w.addr_inc = r1[11];
            w.flag_sel = r1[13:12];
            w.flag_op  = flag_op_t'(r1[15:14]);
            drive(w, r2[31:16]);
         end
         settle();
         report_test("random microwords", e0);

         // Busy word held during the reset edge
         e0 = errors;
         @(posedge clk);
         rst      <= 1'b0;
         uword    <= make_word(SRC_EXT, DST_ADDR, 3'd5, 1'b1, 2'd2, FLAG_SET);
         ext_data <= 16'h7E57;
         @(posedge clk);
         rst      <= 1'b1;
         uword    <= make_word(SRC_REG, DST_NONE, 3'd5, 1'b0, 2'd0, FLAG_HOLD);
         wait_reset_release(4);
         settle();
         check_bus(bus_data, '0);  // R5 cleared
         check_addr(addr, '0);
         check_flags(flags, '0);
         report_test("mid-run reset", e0);

         $display("Closing: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
         if (tests_failed == 0 && errors == 0 && !timed_out) begin
            $display("All tests passed");
         end else begin
            $display("Some tests failed");
         end
      end
      $finish;
   end

endmodule

/* src.f */
board_pkg.sv
microword_decoder.sv
register_bank.sv
address_register.sv
jk_flag_unit.sv
register_board.sv
tb_register_board.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the register board testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -f src.f --top-module tb_register_board -o tb_register_board

output="$(./obj_dir/tb_register_board)"
echo "$output"

if grep -q "All tests passed" <<< "$output"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
